/* logic/shell_cfg_pkg.sv */
// Register layouts assume a 32-bit shell control bus, exactly four scrubbers and three DDR stat ports

package shell_cfg_pkg;

   // ----------------------------------------
   // Control word and scrubber status
   // ----------------------------------------

   // Bit 31 debug enable, 30:28 debug memory select, 3:0 scrubber enables
   typedef struct packed {
      logic       dbg_en;
      logic [2:0] dbg_sel;
      logic [23:0] rsvd;
      logic       en_c;
      logic       en_d;
      logic       en_b;
      logic       en_a;
   } ctl_word_t;

   localparam int SCRB_ADDR_W = 64;
   localparam int NUM_SCRB    = 4;

   typedef logic [2:0]             scrb_state_t;
   typedef logic [SCRB_ADDR_W-1:0] scrb_addr_t;

   // Fixed fields of the status and ID words
   localparam logic [19:0] STATUS_TAG  = 20'hA1111;
   localparam logic [3:0]  STATUS_MARK = 4'hF;
   localparam logic [31:0] CL_ID0      = 32'hF000_1D0F;
   localparam logic [31:0] CL_ID1      = 32'h1D51_FEDD;

   // ----------------------------------------
   // DDR statistics channels
   // ----------------------------------------
   localparam int NUM_STAT_CH = 3;
   localparam int STAT_STAGES = 4;

   typedef struct packed {
      logic        wr;
      logic        rd;
      logic [7:0]  addr;
      logic [31:0] wdata;
   } stat_req_t;

   typedef struct packed {
      logic        ack;
      logic [7:0]  intr;
      logic [31:0] rdata;
   } stat_ack_t;

endpackage

/* logic/dma_data_pkg.sv */
// DMA read data is a fixed 512-bit beat of eight 64-bit lanes; IDs are 6 bits wide

package dma_data_pkg;

   // ----------------------------------------
   // Read channel widths
   // ----------------------------------------
   localparam int DATA_W = 512;
   localparam int ID_W   = 6;
   localparam int RESP_W = 2;

   // ----------------------------------------
   // Lane split of the data beat
   // ----------------------------------------
   localparam int LANES  = 8;
   localparam int LANE_W = 64;
   localparam int HALF_W = 32;

   // Full beat and channel side fields
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ID_W-1:0]   id_t;
   typedef logic [RESP_W-1:0] resp_t;

   // One lane and one operand half of a lane
   typedef logic [LANE_W-1:0] lane_t;
   typedef logic [HALF_W-1:0] half_t;

endpackage

/* logic/scrb_status_if.sv */
// Plain level signals with no handshake; state, addr and done must be synchronous to clk

`timescale 1ns/100ps

interface scrb_status_if
   import shell_cfg_pkg::*;
();

   logic        enable;
   scrb_state_t state;
   scrb_addr_t  addr;
   logic        done;

   // Register block drives the enable and reads back status
   modport regs (output enable, input state, input addr, input done);

   // External scrubber side
   modport scrubber (input enable, output state, output addr, output done);

endinterface

/* logic/pcis_rd_if.sv */
// Read data channel only; a beat moves on a cycle where rvalid and rready are both high

`timescale 1ns/100ps

interface pcis_rd_if
   import dma_data_pkg::*;
(
   input logic clk
);

   logic  rvalid;
   logic  rready;
   data_t rdata;
   id_t   rid;
   logic  rlast;
   resp_t rresp;

   // Sender of read beats
   modport src (input clk, output rvalid, output rdata, output rid, output rlast,
                output rresp, input rready);

   // Receiver of read beats
   modport dst (input clk, input rvalid, input rdata, input rid, input rlast,
                input rresp, output rready);

endinterface

/* logic/stage_pipe.sv */
// Fixed latency of STAGES cycles with no stall or enable; STAGES must be 1 or more

`timescale 1ns/100ps

module stage_pipe
#(
   parameter type payload_t = logic,
   parameter int  STAGES    = 1
)
(
   input  logic     clk,
   input  logic     sync_rst_n,
   input  payload_t in_data,
   output payload_t out_data
);

   payload_t stage_q [STAGES];

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
         begin
            stage_q[i] <= '0;
         end
      end
      else
      begin
         stage_q[0] <= in_data;
         for (int i = 1; i < STAGES; i++)
         begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   assign out_data = stage_q[STAGES-1];

   // An unknown input shows up here STAGES cycles later
   out_known_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      !$isunknown(out_data))
      else $error("stage_pipe output carries unknown bits");

endmodule

/* logic/shell_ctl_regs.sv */
// Scrubber status is sampled live and must be synchronous to clk; debug selectors 4 to 7 show A

`timescale 1ns/100ps

module shell_ctl_regs
   import shell_cfg_pkg::*;
(
   input  logic               clk,
   input  logic               sync_rst_n,
   input  ctl_word_t          sh_cl_ctl0,
   input  logic               sh_cl_flr_assert,
   input  logic               sh_cl_ddr_is_ready,
   input  logic [2:0]         lcl_ddr_is_ready,
   scrb_status_if.regs        scrb_a,
   scrb_status_if.regs        scrb_b,
   scrb_status_if.regs        scrb_c,
   scrb_status_if.regs        scrb_d,
   output logic [31:0]        cl_sh_status0,
   output logic [31:0]        cl_sh_id0,
   output logic [31:0]        cl_sh_id1,
   output logic               cl_sh_flr_done
);

   ctl_word_t             ctl_q;
   logic                  ddr_ready_q;
   logic                  flr_assert_q;
   logic [NUM_SCRB-1:0]   ready_vec;
   logic [NUM_SCRB-1:0]   done_vec;
   scrb_addr_t            dbg_addr;

   // ----------------------------------------
   // Control and readiness capture
   // ----------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl_q       <= '0;
         ddr_ready_q <= 1'b0;
      end
      else
      begin
         ctl_q       <= sh_cl_ctl0;
         ddr_ready_q <= sh_cl_ddr_is_ready;
      end
   end

   // Note D sits below C in the control word
   assign scrb_a.enable = ctl_q.en_a;
   assign scrb_b.enable = ctl_q.en_b;
   assign scrb_c.enable = ctl_q.en_c;
   assign scrb_d.enable = ctl_q.en_d;

   // Shell readiness slots in between the local controllers
   assign ready_vec = {lcl_ddr_is_ready[2], ddr_ready_q, lcl_ddr_is_ready[1:0]};
   assign done_vec  = {scrb_c.done, scrb_d.done, scrb_b.done, scrb_a.done};

   // ----------------------------------------
   // FLR responder
   // ----------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q   <= 1'b0;
         cl_sh_flr_done <= 1'b0;
      end
      else
      begin
         flr_assert_q   <= sh_cl_flr_assert;
         cl_sh_flr_done <= flr_assert_q && !cl_sh_flr_done;
      end
   end

   // ----------------------------------------
   // Status and ID words
   // ----------------------------------------
   always_comb
   begin
      case (ctl_q.dbg_sel)
         3'd3:    dbg_addr = scrb_c.addr;
         3'd2:    dbg_addr = scrb_d.addr;
         3'd1:    dbg_addr = scrb_b.addr;
         default: dbg_addr = scrb_a.addr;
      endcase
   end

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         cl_sh_status0 <= '0;
         cl_sh_id0     <= '0;
         cl_sh_id1     <= '0;
      end
      else if (ctl_q.dbg_en)
      begin
         // Per-scrubber FSM states in nibbles, C highest
         cl_sh_status0 <= {1'b0, scrb_c.state, 1'b0, scrb_d.state,
                           1'b0, scrb_b.state, 1'b0, scrb_a.state,
                           4'h0, STATUS_MARK, done_vec, ready_vec};
         cl_sh_id0     <= dbg_addr[31:0];
         cl_sh_id1     <= dbg_addr[SCRB_ADDR_W-1 -: 32];
      end
      else
      begin
         cl_sh_status0 <= {STATUS_TAG, STATUS_MARK, done_vec, ready_vec};
         cl_sh_id0     <= CL_ID0;
         cl_sh_id1     <= CL_ID1;
      end
   end

   // Held request must give a toggling done, never a level
   flr_done_pulse_a : assert property (@(posedge clk) disable iff (!sync_rst_n)
      cl_sh_flr_done |=> !cl_sh_flr_done)
      else $error("flr_done high on two consecutive cycles");

endmodule

/* logic/read_product_lanes.sv */
// Purely combinational; upstream must hold rdata free of unknown bits whenever rvalid is high

`timescale 1ns/100ps

module read_product_lanes
   import dma_data_pkg::*;
(
   pcis_rd_if.dst up,
   pcis_rd_if.src down
);

   data_t prod_data;

   // ----------------------------------------
   // Lane products
   // ----------------------------------------
   // Lane order is reversed, so output lane 0 comes from input lane 7
   always_comb
   begin
      lane_t src_lane;
      half_t op_hi;
      half_t op_lo;
      prod_data = '0;
      for (int k = 0; k < LANES; k++)
      begin
         src_lane = up.rdata[(LANES-1-k)*LANE_W +: LANE_W];
         op_hi    = src_lane[LANE_W-1 -: HALF_W];
         op_lo    = src_lane[HALF_W-1:0];
         // Widen first so the full 64-bit product is kept
         prod_data[k*LANE_W +: LANE_W] = lane_t'(op_hi) * lane_t'(op_lo);
      end
   end

   assign down.rdata  = prod_data;
   assign down.rvalid = up.rvalid;
   assign down.rid    = up.rid;
   assign down.rlast  = up.rlast;
   assign down.rresp  = up.rresp;

   // Back-pressure goes straight upstream
   assign up.rready   = down.rready;

   rdata_known_a : assert property (@(posedge up.clk)
      up.rvalid |-> !$isunknown(up.rdata))
      else $error("read data has unknown bits on a valid beat");

endmodule

/* logic/cl_product_top.sv */
// Expects sync_rst_n already synchronized to clk; scrubber index 0 is A, 1 B, 2 C and 3 D

`timescale 1ns/100ps

module cl_product_top
   import shell_cfg_pkg::*;
   import dma_data_pkg::*;
(
   input  logic                 clk,
   input  logic                 sync_rst_n,

   input  ctl_word_t            sh_cl_ctl0,
   input  logic                 sh_cl_flr_assert,
   input  logic                 sh_cl_ddr_is_ready,
   input  logic [2:0]           lcl_ddr_is_ready,

   input  scrb_state_t          scrb_state [NUM_SCRB],
   input  scrb_addr_t           scrb_addr [NUM_SCRB],
   input  logic [NUM_SCRB-1:0]  scrb_done,
   output logic [NUM_SCRB-1:0]  scrb_enable,
   output logic [31:0]          cl_sh_status0,
   output logic [31:0]          cl_sh_id0,
   output logic [31:0]          cl_sh_id1,
   output logic                 cl_sh_flr_done,

   input  logic                 pcis_rvalid,
   output logic                 pcis_rready,
   input  data_t                pcis_rdata,
   input  id_t                  pcis_rid,
   input  logic                 pcis_rlast,
   input  resp_t                pcis_rresp,
   output logic                 prod_rvalid,
   input  logic                 prod_rready,
   output data_t                prod_rdata,
   output id_t                  prod_rid,
   output logic                 prod_rlast,
   output resp_t                prod_rresp,

   input  stat_req_t            sh_stat_req [NUM_STAT_CH],
   output stat_req_t            ddr_stat_req [NUM_STAT_CH],
   input  stat_ack_t            ddr_stat_ack [NUM_STAT_CH],
   output stat_ack_t            sh_stat_ack [NUM_STAT_CH]
);

   // ----------------------------------------
   // Scrubber status buses
   // ----------------------------------------
   scrb_status_if scrb_a ();
   scrb_status_if scrb_b ();
   scrb_status_if scrb_c ();
   scrb_status_if scrb_d ();

   assign scrb_a.state = scrb_state[0];
   assign scrb_a.addr  = scrb_addr[0];
   assign scrb_a.done  = scrb_done[0];
   assign scrb_b.state = scrb_state[1];
   assign scrb_b.addr  = scrb_addr[1];
   assign scrb_b.done  = scrb_done[1];
   assign scrb_c.state = scrb_state[2];
   assign scrb_c.addr  = scrb_addr[2];
   assign scrb_c.done  = scrb_done[2];
   assign scrb_d.state = scrb_state[3];
   assign scrb_d.addr  = scrb_addr[3];
   assign scrb_d.done  = scrb_done[3];

   assign scrb_enable = {scrb_d.enable, scrb_c.enable, scrb_b.enable, scrb_a.enable};

   shell_ctl_regs shell_ctl_regs_inst (
      .clk                (clk),
      .sync_rst_n         (sync_rst_n),
      .sh_cl_ctl0         (sh_cl_ctl0),
      .sh_cl_flr_assert   (sh_cl_flr_assert),
      .sh_cl_ddr_is_ready (sh_cl_ddr_is_ready),
      .lcl_ddr_is_ready   (lcl_ddr_is_ready),
      .scrb_a             (scrb_a),
      .scrb_b             (scrb_b),
      .scrb_c             (scrb_c),
      .scrb_d             (scrb_d),
      .cl_sh_status0      (cl_sh_status0),
      .cl_sh_id0          (cl_sh_id0),
      .cl_sh_id1          (cl_sh_id1),
      .cl_sh_flr_done     (cl_sh_flr_done)
   );

   // ----------------------------------------
   // Read data path
   // ----------------------------------------
   pcis_rd_if pcis_up (.clk(clk));
   pcis_rd_if pcis_down (.clk(clk));

   assign pcis_up.rvalid   = pcis_rvalid;
   assign pcis_up.rdata    = pcis_rdata;
   assign pcis_up.rid      = pcis_rid;
   assign pcis_up.rlast    = pcis_rlast;
   assign pcis_up.rresp    = pcis_rresp;
   assign pcis_rready      = pcis_up.rready;

   assign prod_rvalid      = pcis_down.rvalid;
   assign prod_rdata       = pcis_down.rdata;
   assign prod_rid         = pcis_down.rid;
   assign prod_rlast       = pcis_down.rlast;
   assign prod_rresp       = pcis_down.rresp;
   assign pcis_down.rready = prod_rready;

   read_product_lanes read_product_lanes_inst (
      .up   (pcis_up),
      .down (pcis_down)
   );

   // ----------------------------------------
   // DDR statistics pipelines
   // ----------------------------------------
   for (genvar ch = 0; ch < NUM_STAT_CH; ch++)
   begin : g_stat
      // Requests toward the controller
      stage_pipe #(.payload_t(stat_req_t), .STAGES(STAT_STAGES)) req_pipe_inst (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .in_data    (sh_stat_req[ch]),
         .out_data   (ddr_stat_req[ch])
      );

      // Acknowledges back to the shell
      stage_pipe #(.payload_t(stat_ack_t), .STAGES(STAT_STAGES)) ack_pipe_inst (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .in_data    (ddr_stat_ack[ch]),
         .out_data   (sh_stat_ack[ch])
      );
   end

endmodule

/* verif/tb_cl_product.sv */
// Fixed-latency directed tests driven 1 ns after the rising edge; the run stops at the first error

`timescale 1ns/100ps

module tb_cl_product
   import shell_cfg_pkg::*;
   import dma_data_pkg::*;
();

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 5;

   // Test lengths in cycles, also used to size the watchdog
   localparam int N_ENABLE    = 6;
   localparam int N_STATUS    = 6;
   localparam int N_DEBUG_SEL = 5;
   localparam int N_STAT      = 20;
   localparam int N_BEATS     = 24;
   localparam int RESET_LEN   = RESET_CYCLES + 1;
   localparam int STATUS_LEN  = N_STATUS * 2;
   localparam int DEBUG_LEN   = N_DEBUG_SEL * 2 + 1;
   localparam int FLR_LEN     = 5 + 9;
   localparam int STAT_LEN    = N_STAT + STAT_STAGES;
   localparam int TEST_CYCLES = RESET_LEN + N_ENABLE + STATUS_LEN + DEBUG_LEN + FLR_LEN
                                + STAT_LEN + N_BEATS;
   localparam int WATCHDOG_NS = TEST_CYCLES * 2 * CLK_PERIOD;

   logic                clk;
   logic                sync_rst_n;
   ctl_word_t           sh_cl_ctl0;
   logic                sh_cl_flr_assert;
   logic                sh_cl_ddr_is_ready;
   logic [2:0]          lcl_ddr_is_ready;
   scrb_state_t         scrb_state [NUM_SCRB];
   scrb_addr_t          scrb_addr [NUM_SCRB];
   logic [NUM_SCRB-1:0] scrb_done;
   logic [NUM_SCRB-1:0] scrb_enable;
   logic [31:0]         cl_sh_status0;
   logic [31:0]         cl_sh_id0;
   logic [31:0]         cl_sh_id1;
   logic                cl_sh_flr_done;

   logic                pcis_rvalid;
   logic                pcis_rready;
   data_t               pcis_rdata;
   id_t                 pcis_rid;
   logic                pcis_rlast;
   resp_t               pcis_rresp;
   logic                prod_rvalid;
   logic                prod_rready;
   data_t               prod_rdata;
   id_t                 prod_rid;
   logic                prod_rlast;
   resp_t               prod_rresp;

   stat_req_t           sh_stat_req [NUM_STAT_CH];
   stat_req_t           ddr_stat_req [NUM_STAT_CH];
   stat_ack_t           ddr_stat_ack [NUM_STAT_CH];
   stat_ack_t           sh_stat_ack [NUM_STAT_CH];

   integer              seed;

   cl_product_top cl_product_top_inst (
      .clk                (clk),
      .sync_rst_n         (sync_rst_n),
      .sh_cl_ctl0         (sh_cl_ctl0),
      .sh_cl_flr_assert   (sh_cl_flr_assert),
      .sh_cl_ddr_is_ready (sh_cl_ddr_is_ready),
      .lcl_ddr_is_ready   (lcl_ddr_is_ready),
      .scrb_state         (scrb_state),
      .scrb_addr          (scrb_addr),
      .scrb_done          (scrb_done),
      .scrb_enable        (scrb_enable),
      .cl_sh_status0      (cl_sh_status0),
      .cl_sh_id0          (cl_sh_id0),
      .cl_sh_id1          (cl_sh_id1),
      .cl_sh_flr_done     (cl_sh_flr_done),
      .pcis_rvalid        (pcis_rvalid),
      .pcis_rready        (pcis_rready),
      .pcis_rdata         (pcis_rdata),
      .pcis_rid           (pcis_rid),
      .pcis_rlast         (pcis_rlast),
      .pcis_rresp         (pcis_rresp),
      .prod_rvalid        (prod_rvalid),
      .prod_rready        (prod_rready),
      .prod_rdata         (prod_rdata),
      .prod_rid           (prod_rid),
      .prod_rlast         (prod_rlast),
      .prod_rresp         (prod_rresp),
      .sh_stat_req        (sh_stat_req),
      .ddr_stat_req       (ddr_stat_req),
      .ddr_stat_ack       (ddr_stat_ack),
      .sh_stat_ack        (sh_stat_ack)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ----------------------------------------
   // Compare tasks
   // ----------------------------------------
   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp)
      begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         $display("CHECKS FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic check_req(input string name, input stat_req_t exp, input stat_req_t act);
      if (act !== exp)
      begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         $display("CHECKS FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic check_ack(input string name, input stat_ack_t exp, input stat_ack_t act);
      if (act !== exp)
      begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         $display("CHECKS FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp)
      begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         $display("CHECKS FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   // ----------------------------------------
   // Stimulus helpers
   // ----------------------------------------
   function automatic logic [31:0] rand_word();
      rand_word = $random(seed);
   endfunction

   function automatic stat_req_t rand_req();
      logic [63:0] r;
      r = {rand_word(), rand_word()};
      rand_req = stat_req_t'(r[$bits(stat_req_t)-1:0]);
   endfunction

   function automatic stat_ack_t rand_ack();
      logic [63:0] r;
      r = {rand_word(), rand_word()};
      rand_ack = stat_ack_t'(r[$bits(stat_ack_t)-1:0]);
   endfunction

   function automatic data_t rand_beat();
      data_t d;
      for (int w = 0; w < DATA_W / 32; w++)
      begin
         d[w*32 +: 32] = rand_word();
      end
      rand_beat = d;
   endfunction

   // Index order of the inputs is A, B, C, D
   function automatic logic [3:0] done_order();
      return {scrb_done[2], scrb_done[3], scrb_done[1], scrb_done[0]};
   endfunction

   function automatic logic [3:0] ready_order();
      return {lcl_ddr_is_ready[2], sh_cl_ddr_is_ready, lcl_ddr_is_ready[1:0]};
   endfunction

   function automatic logic [31:0] normal_status_word();
      return {STATUS_TAG, STATUS_MARK, done_order(), ready_order()};
   endfunction

   function automatic logic [31:0] debug_status_word();
      return {1'b0, scrb_state[2], 1'b0, scrb_state[3], 1'b0, scrb_state[1],
              1'b0, scrb_state[0], 4'h0, STATUS_MARK, done_order(), ready_order()};
   endfunction

   // Debug selector to scrubber input index
   function automatic int scrubber_for_sel(input int sel);
      case (sel)
         3:       return 2;
         2:       return 3;
         1:       return 1;
         default: return 0;
      endcase
   endfunction

   task automatic next_cycle(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic init_inputs();
      clk                = 1'b0;
      sync_rst_n         = 1'b0;
      sh_cl_ctl0         = '0;
      sh_cl_flr_assert   = 1'b0;
      sh_cl_ddr_is_ready = 1'b0;
      lcl_ddr_is_ready   = '0;
      scrb_done          = '0;
      pcis_rvalid        = 1'b0;
      pcis_rdata         = '0;
      pcis_rid           = '0;
      pcis_rlast         = 1'b0;
      pcis_rresp         = '0;
      prod_rready        = 1'b0;
      for (int i = 0; i < NUM_SCRB; i++)
      begin
         scrb_state[i] = '0;
         scrb_addr[i]  = '0;
      end
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         sh_stat_req[ch]  = '0;
         ddr_stat_ack[ch] = '0;
      end
   endtask

   task automatic drive_scrubber_inputs();
      logic [31:0] r;
      for (int i = 0; i < NUM_SCRB; i++)
      begin
         r             = rand_word();
         scrb_state[i] = r[2:0];
         scrb_done[i]  = r[3];
         scrb_addr[i]  = {rand_word(), rand_word()};
      end
      r                  = rand_word();
      sh_cl_ddr_is_ready = r[0];
      lcl_ddr_is_ready   = r[3:1];
   endtask

   // ----------------------------------------
   // Directed tests
   // ----------------------------------------
   task automatic check_reset_outputs();
      check_word("scrb_enable", 32'h0, 32'(scrb_enable));
      check_word("cl_sh_flr_done", 32'h0, 32'(cl_sh_flr_done));
      check_word("cl_sh_status0", 32'h0, cl_sh_status0);
      check_word("cl_sh_id0", 32'h0, cl_sh_id0);
      check_word("cl_sh_id1", 32'h0, cl_sh_id1);
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         check_req($sformatf("ddr_stat_req[%0d]", ch), '0, ddr_stat_req[ch]);
         check_ack($sformatf("sh_stat_ack[%0d]", ch), '0, sh_stat_ack[ch]);
      end
   endtask

   task automatic test_reset();
      // Busy inputs while in reset must not reach any register
      sh_cl_ctl0         = ctl_word_t'(32'hFFFF_FFFF);
      sh_cl_flr_assert   = 1'b1;
      sh_cl_ddr_is_ready = 1'b1;
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         sh_stat_req[ch]  = rand_req();
         ddr_stat_ack[ch] = rand_ack();
      end
      next_cycle(2);
      check_reset_outputs();
      next_cycle(RESET_CYCLES - 2);
      sync_rst_n         = 1'b1;
      sh_cl_ctl0         = '0;
      sh_cl_flr_assert   = 1'b0;
      sh_cl_ddr_is_ready = 1'b0;
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         sh_stat_req[ch]  = '0;
         ddr_stat_ack[ch] = '0;
      end
      #1;
      // Nothing has been clocked out of reset yet
      check_reset_outputs();
      next_cycle(1);
   endtask

   task automatic test_enables();
      logic [31:0] word;
      for (int i = 0; i < N_ENABLE; i++)
      begin
         word      = rand_word();
         word[31]  = 1'b0;
         // Walk a single enable first, then random patterns
         if (i < 4)
            word[3:0] = 4'(1 << i);
         sh_cl_ctl0 = ctl_word_t'(word);
         next_cycle(1);
         check_word("scrb_enable", 32'({word[2], word[3], word[1], word[0]}),
                    32'(scrb_enable));
      end
   endtask

   task automatic test_normal_status();
      logic [31:0] word;
      for (int i = 0; i < N_STATUS; i++)
      begin
         drive_scrubber_inputs();
         word       = rand_word();
         word[31]   = 1'b0;
         sh_cl_ctl0 = ctl_word_t'(word);
         next_cycle(2);
         check_word("cl_sh_status0", normal_status_word(), cl_sh_status0);
         check_word("cl_sh_id0", CL_ID0, cl_sh_id0);
         check_word("cl_sh_id1", CL_ID1, cl_sh_id1);
      end
   endtask

   task automatic test_debug();
      int          sel_list [N_DEBUG_SEL] = '{0, 1, 2, 3, 7};
      logic [31:0] word;
      int          idx;
      for (int i = 0; i < N_DEBUG_SEL; i++)
      begin
         drive_scrubber_inputs();
         word        = rand_word();
         word[31]    = 1'b1;
         word[30:28] = 3'(sel_list[i]);
         sh_cl_ctl0  = ctl_word_t'(word);
         next_cycle(2);
         idx = scrubber_for_sel(sel_list[i]);
         check_word("cl_sh_status0", debug_status_word(), cl_sh_status0);
         check_word("cl_sh_id0", scrb_addr[idx][31:0], cl_sh_id0);
         check_word("cl_sh_id1", scrb_addr[idx][63:32], cl_sh_id1);
      end
      sh_cl_ctl0 = '0;
      next_cycle(1);
   endtask

   task automatic test_flr();
      // One-cycle request
      sh_cl_flr_assert = 1'b1;
      for (int i = 1; i <= 5; i++)
      begin
         next_cycle(1);
         check_word("cl_sh_flr_done", 32'(i == 2), 32'(cl_sh_flr_done));
         sh_cl_flr_assert = 1'b0;
      end

      // Request held for six cycles toggles done
      sh_cl_flr_assert = 1'b1;
      for (int i = 1; i <= 9; i++)
      begin
         next_cycle(1);
         check_word("cl_sh_flr_done", 32'(i >= 2 && i <= 6 && i % 2 == 0),
                    32'(cl_sh_flr_done));
         if (i == 6)
            sh_cl_flr_assert = 1'b0;
      end
   endtask

   task automatic test_stats();
      stat_req_t req_hist [NUM_STAT_CH][N_STAT];
      stat_ack_t ack_hist [NUM_STAT_CH][N_STAT];
      for (int n = 0; n < N_STAT + STAT_STAGES; n++)
      begin
         if (n >= STAT_STAGES)
         begin
            for (int ch = 0; ch < NUM_STAT_CH; ch++)
            begin
               check_req($sformatf("ddr_stat_req[%0d]", ch),
                         req_hist[ch][n-STAT_STAGES], ddr_stat_req[ch]);
               check_ack($sformatf("sh_stat_ack[%0d]", ch),
                         ack_hist[ch][n-STAT_STAGES], sh_stat_ack[ch]);
            end
         end
         if (n < N_STAT)
         begin
            for (int ch = 0; ch < NUM_STAT_CH; ch++)
            begin
               req_hist[ch][n]  = rand_req();
               ack_hist[ch][n]  = rand_ack();
               sh_stat_req[ch]  = req_hist[ch][n];
               ddr_stat_ack[ch] = ack_hist[ch][n];
            end
         end
         next_cycle(1);
      end
   endtask

   task automatic test_product();
      data_t       exp_data;
      lane_t       lane;
      logic [31:0] r;
      for (int b = 0; b < N_BEATS; b++)
      begin
         r           = rand_word();
         pcis_rdata  = rand_beat();
         pcis_rid    = r[5:0];
         pcis_rlast  = r[6];
         pcis_rresp  = r[8:7];
         pcis_rvalid = r[9];
         // A stretch with the consumer stalled
         prod_rready = (b >= 8 && b < 14) ? 1'b0 : r[10];
         #2;
         for (int k = 0; k < LANES; k++)
         begin
            lane = pcis_rdata[(LANES-1-k)*LANE_W +: LANE_W];
            exp_data[k*LANE_W +: LANE_W] = {32'h0, lane[63:32]} * {32'h0, lane[31:0]};
         end
         check_data("prod_rdata", exp_data, prod_rdata);
         check_word("prod_rvalid", 32'(pcis_rvalid), 32'(prod_rvalid));
         check_word("prod_rid", 32'(pcis_rid), 32'(prod_rid));
         check_word("prod_rlast", 32'(pcis_rlast), 32'(prod_rlast));
         check_word("prod_rresp", 32'(pcis_rresp), 32'(prod_rresp));
         check_word("pcis_rready", 32'(prod_rready), 32'(pcis_rready));
         next_cycle(1);
      end
   endtask

   // ----------------------------------------
   // Sequence and watchdog
   // ----------------------------------------
   initial
   begin
      seed = 32'he5b1a60c;
      init_inputs();
      test_reset();
      test_enables();
      test_normal_status();
      test_debug();
      test_flr();
      test_stats();
      test_product();
      $display("ALL CHECKS PASSED");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("CHECKS FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

/* build.f */
logic/shell_cfg_pkg.sv
logic/dma_data_pkg.sv
logic/scrb_status_if.sv
logic/pcis_rd_if.sv
logic/stage_pipe.sv
logic/shell_ctl_regs.sv
logic/read_product_lanes.sv
logic/cl_product_top.sv
verif/tb_cl_product.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator; exit status follows the pass message in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f build.f --top-module tb_cl_product -Mdir obj_dir -o sim_cl_product \
   && ./obj_dir/sim_cl_product | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
   && echo "run_sim: pass" \
   || { echo "run_sim: fail"; exit 1; }
